// File: common/sat_pkg.sv
// problem dimensions plus the slot, variable and break-count types of the flip datapath
package sat_pkg;

    // literals per clause, this stage is built for 3-SAT only
    localparam int NSAT = 3;

    // slot index width, one code above the last slot is kept free
    localparam int SLOT_W = 2;

    // break counts saturate well below 32 in practice
    localparam int BREAK_W = 5;

    // the widest variable index any instance may use
    localparam int MAX_VAR_W = 8;

    // a variable index at full width, narrower instances zero extend into it
    typedef logic [MAX_VAR_W-1:0] var_id_t;

    // number of clauses that would become unsatisfied by flipping a variable
    typedef logic [BREAK_W-1:0] break_t;

    // position of a literal inside its clause
    typedef logic [SLOT_W-1:0] slot_t;

    // marks a result where no candidate was valid
    localparam slot_t NO_SLOT = slot_t'(3);

endpackage : sat_pkg

// File: common/flip_cfg_pkg.sv
// configuration register map, register reset values and LFSR feedback constants
package flip_cfg_pkg;

    // the write port has a one bit address
    localparam logic CFG_ADDR_THRESHOLD = 1'b0;
    localparam logic CFG_ADDR_SEED      = 1'b1;

    // a random word above this value triggers a random walk
    // this default walks roughly 57 percent of the time
    localparam logic [31:0] THRESHOLD_RESET = 32'h6E147AE0;

    // any nonzero start value works, zero would lock the generator
    localparam logic [31:0] SEED_RESET = 32'hACE1_2468;

    // right shifting Galois mask for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

endpackage : flip_cfg_pkg

// File: common/cand_if.sv
// cand_if interface carrying one clause's three candidates to the selector
`timescale 1ns/1ps

interface cand_if #(
    parameter int VAR_W = 6
);

    logic                                       valid;  // one cycle strobe per clause
    logic [sat_pkg::NSAT-1:0][VAR_W-1:0]        var_id; // variable index per slot
    sat_pkg::break_t [sat_pkg::NSAT-1:0]        brk;    // break count per slot
    logic [sat_pkg::NSAT-1:0]                   mask;   // slot holds a usable literal

    // the break table drives a whole clause at once
    modport tbl (
        output valid,
        output var_id,
        output brk,
        output mask
    );

    // the selector consumes every strobe, there is no stall path back
    modport sel (
        input valid,
        input var_id,
        input brk,
        input mask
    );

endinterface : cand_if

// File: design/flip_config_regs.sv
// flip_config_regs module holding the random-walk threshold and the LFSR seed
`timescale 1ns/1ps

module flip_config_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        cfg_we_i,
    input  logic        cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,
    output logic [31:0] threshold_o,
    output logic [31:0] seed_o,
    output logic        seed_load_o
);

    logic wr_threshold;
    logic wr_seed;

    assign wr_threshold = cfg_we_i && (cfg_addr_i == flip_cfg_pkg::CFG_ADDR_THRESHOLD);
    assign wr_seed      = cfg_we_i && (cfg_addr_i == flip_cfg_pkg::CFG_ADDR_SEED);

    always_ff @(posedge clk) begin
        if (reset) begin
            threshold_o <= flip_cfg_pkg::THRESHOLD_RESET;
            seed_o      <= flip_cfg_pkg::SEED_RESET;  // matches the LFSR start value
            seed_load_o <= 1'b0;
        end else begin
            if (wr_threshold) begin
                threshold_o <= cfg_wdata_i;
            end
            if (wr_seed) begin
                seed_o <= cfg_wdata_i;
            end
            seed_load_o <= wr_seed;  // the LFSR picks seed_o up one edge later
        end
    end

    // a zero seed would reach the LFSR on the following edge and freeze it there
    property p_seed_nonzero;
        @(posedge clk) disable iff (reset)
            wr_seed |=> (seed_o != 32'd0);
    endproperty

    a_seed_nonzero : assert property (p_seed_nonzero)
        else $error("seed register written with zero, LFSR would lock");

endmodule : flip_config_regs

// File: design/walk_lfsr.sv
// walk_lfsr module, a 32-bit Galois LFSR giving one random word per cycle
`timescale 1ns/1ps

module walk_lfsr (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] seed_i,
    input  logic        load_i,
    output logic [31:0] random_o
);

    logic [31:0] state_q;
    logic [31:0] state_next;

    // shift right and fold the taps back in whenever a one falls out
    always_comb begin
        state_next = state_q >> 1;
        if (state_q[0]) begin
            state_next = state_next ^ flip_cfg_pkg::LFSR_TAPS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= flip_cfg_pkg::SEED_RESET;
        end else if (load_i) begin
            state_q <= seed_i;  // a reload replaces the step for that cycle
        end else begin
            state_q <= state_next;
        end
    end

    assign random_o = state_q;

    // zero is the one state the feedback can never leave
    property p_state_nonzero;
        @(posedge clk) disable iff (reset)
            state_q != 32'd0;
    endproperty

    a_state_nonzero : assert property (p_state_nonzero)
        else $error("LFSR state reached zero");

endmodule : walk_lfsr

// File: break_table/break_table.sv
// break_table module, a per-variable break-count register file with a three-way read
`timescale 1ns/1ps

module break_table #(
    parameter int NUM_VARS = 64,
    parameter int VAR_W    = 6
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                bt_we_i,
    input  logic [VAR_W-1:0]                    bt_var_i,
    input  sat_pkg::break_t                     bt_value_i,
    input  logic                                req_i,
    input  logic [sat_pkg::NSAT-1:0][VAR_W-1:0] req_var_i,
    input  logic [sat_pkg::NSAT-1:0]            req_mask_i,
    cand_if.tbl                                 cand
);

    sat_pkg::break_t brk_mem [NUM_VARS];

    // indices widened to the package width for range checks
    sat_pkg::var_id_t         wr_idx;
    logic [sat_pkg::NSAT-1:0] rd_in_range;

    assign wr_idx = sat_pkg::var_id_t'(bt_var_i);

    always_comb begin
        for (int i = 0; i < sat_pkg::NSAT; i++) begin
            rd_in_range[i] = int'(sat_pkg::var_id_t'(req_var_i[i])) < NUM_VARS;
        end
    end

    // a new solver run starts with every count at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                brk_mem[v] <= '0;
            end
        end else if (bt_we_i) begin
            brk_mem[bt_var_i] <= bt_value_i;
        end
    end

    // the read samples the array before this edge's write lands
    always_ff @(posedge clk) begin
        if (req_i) begin
            for (int i = 0; i < sat_pkg::NSAT; i++) begin
                cand.brk[i] <= brk_mem[req_var_i[i]];
            end
            cand.var_id <= req_var_i;
            cand.mask   <= req_mask_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cand.valid <= 1'b0;
        end else begin
            cand.valid <= req_i;  // one strobe per request, never stretched
        end
    end

    property p_write_in_range;
        @(posedge clk) disable iff (reset)
            bt_we_i |-> (int'(wr_idx) < NUM_VARS);
    endproperty

    // masked off slots may carry any index
    property p_read_in_range;
        @(posedge clk) disable iff (reset)
            req_i |-> ((req_mask_i & rd_in_range) == req_mask_i);
    endproperty

    a_write_in_range : assert property (p_write_in_range)
        else $error("break table write beyond NUM_VARS");
    a_read_in_range : assert property (p_read_in_range)
        else $error("break table read of a valid slot beyond NUM_VARS");

endmodule : break_table

// File: selector/heuristic_selector.sv
// heuristic_selector module choosing the variable to flip by zero-break, random-walk and greedy rules
`timescale 1ns/1ps

module heuristic_selector #(
    parameter int VAR_W = 6
) (
    input  logic           clk,
    input  logic           reset,
    cand_if.sel            cand,
    input  logic [31:0]    random_i,
    input  logic [31:0]    threshold_i,
    output logic           flip_valid_o,
    output logic [VAR_W-1:0] flip_var_o,
    output sat_pkg::slot_t flip_slot_o,
    output logic           random_walk_o
);

    localparam logic [sat_pkg::NSAT-1:0] SLOT0_BIT = 1;

    logic [sat_pkg::SLOT_W-1:0] num_valid;
    sat_pkg::slot_t             zero_slot;
    sat_pkg::slot_t             lo_slot;    // lowest valid slot
    sat_pkg::slot_t             hi_slot;    // highest valid slot
    sat_pkg::slot_t             rand_slot;
    sat_pkg::slot_t             greedy_slot;
    sat_pkg::break_t            greedy_brk;
    logic                       walk_en;
    sat_pkg::slot_t             pick_slot;
    logic                       pick_walk;
    logic [VAR_W-1:0]           pick_var;

    // scanning downward leaves the lowest matching slot in place
    always_comb begin
        num_valid = '0;
        zero_slot = sat_pkg::NO_SLOT;
        lo_slot   = sat_pkg::NO_SLOT;
        for (int i = sat_pkg::NSAT - 1; i >= 0; i--) begin
            if (cand.mask[i]) begin
                num_valid = num_valid + 1'b1;
                lo_slot   = sat_pkg::slot_t'(i);
                if (cand.brk[i] == '0) begin
                    zero_slot = sat_pkg::slot_t'(i);
                end
            end
        end
    end

    always_comb begin
        hi_slot = sat_pkg::NO_SLOT;
        for (int i = 0; i < sat_pkg::NSAT; i++) begin
            if (cand.mask[i]) begin
                hi_slot = sat_pkg::slot_t'(i);
            end
        end
    end

    // strict less-than keeps ties on the lower slot
    always_comb begin
        greedy_slot = sat_pkg::NO_SLOT;
        greedy_brk  = '1;
        for (int i = 0; i < sat_pkg::NSAT; i++) begin
            if (cand.mask[i] &&
                (greedy_slot == sat_pkg::NO_SLOT || cand.brk[i] < greedy_brk)) begin
                greedy_slot = sat_pkg::slot_t'(i);
                greedy_brk  = cand.brk[i];
            end
        end
    end

    // a lone candidate leaves nothing to choose between, so it never walks
    assign walk_en = (random_i > threshold_i) && (num_valid >= 2);

    always_comb begin
        if (int'(num_valid) == sat_pkg::NSAT) begin
            rand_slot = sat_pkg::slot_t'(random_i[5:0] % sat_pkg::NSAT);
        end else begin
            rand_slot = random_i[7] ? hi_slot : lo_slot;  // exactly two valid here
        end
    end

    always_comb begin
        pick_walk = 1'b0;
        if (cand.mask == '0) begin
            pick_slot = sat_pkg::NO_SLOT;
        end else if (zero_slot != sat_pkg::NO_SLOT) begin
            pick_slot = zero_slot;
        end else if (walk_en) begin
            pick_slot = rand_slot;
            pick_walk = 1'b1;
        end else begin
            pick_slot = greedy_slot;
        end
    end

    always_comb begin
        pick_var = '0;  // NO_SLOT reports variable 0
        for (int i = 0; i < sat_pkg::NSAT; i++) begin
            if (pick_slot == sat_pkg::slot_t'(i)) begin
                pick_var = cand.var_id[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flip_valid_o  <= 1'b0;
            flip_var_o    <= '0;
            flip_slot_o   <= sat_pkg::NO_SLOT;
            random_walk_o <= 1'b0;
        end else begin
            flip_valid_o <= cand.valid;
            if (cand.valid) begin
                flip_var_o    <= pick_var;
                flip_slot_o   <= pick_slot;
                random_walk_o <= pick_walk;
            end
        end
    end

    // the mask is the one the break table presented a cycle before the result
    property p_slot_masked;
        @(posedge clk) disable iff (reset)
            (flip_valid_o && (flip_slot_o != sat_pkg::NO_SLOT))
                |-> |($past(cand.mask) & (SLOT0_BIT << flip_slot_o));
    endproperty

    a_slot_masked : assert property (p_slot_masked)
        else $error("selector chose slot %0d with its mask bit clear", flip_slot_o);

endmodule : heuristic_selector

// File: design/walksat_flip_unit.sv
// walksat_flip_unit top level joining config registers, LFSR, break table and selector
`timescale 1ns/1ps

module walksat_flip_unit #(
    parameter int NUM_VARS = 64,
    parameter int VAR_W    = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cfg_we_i,
    input  logic                     cfg_addr_i,
    input  logic [31:0]              cfg_wdata_i,
    input  logic                     bt_we_i,
    input  logic [VAR_W-1:0]         bt_var_i,
    input  sat_pkg::break_t          bt_value_i,
    input  logic                     req_i,
    input  logic [VAR_W-1:0]         req_var0_i,
    input  logic [VAR_W-1:0]         req_var1_i,
    input  logic [VAR_W-1:0]         req_var2_i,
    input  logic [sat_pkg::NSAT-1:0] req_mask_i,
    output logic                     flip_valid_o,
    output logic [VAR_W-1:0]         flip_var_o,
    output sat_pkg::slot_t           flip_slot_o,
    output logic                     random_walk_o
);

    // reject instances whose indices would not fit the shared types
    if (VAR_W > sat_pkg::MAX_VAR_W || NUM_VARS > (1 << VAR_W)) begin : g_bad_dims
        $error("walksat_flip_unit: NUM_VARS %0d does not fit VAR_W %0d", NUM_VARS, VAR_W);
    end

    logic [31:0]                         threshold;
    logic [31:0]                         seed;
    logic                                seed_load;
    logic [31:0]                         random_word;
    logic [sat_pkg::NSAT-1:0][VAR_W-1:0] req_var;

    assign req_var = {req_var2_i, req_var1_i, req_var0_i};  // slot 0 in the low bits

    cand_if #(.VAR_W(VAR_W)) cand ();

    flip_config_regs u_cfg (
        .clk         (clk),
        .reset       (reset),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .threshold_o (threshold),
        .seed_o      (seed),
        .seed_load_o (seed_load)
    );

    walk_lfsr u_lfsr (
        .clk      (clk),
        .reset    (reset),
        .seed_i   (seed),
        .load_i   (seed_load),
        .random_o (random_word)
    );

    break_table #(.NUM_VARS(NUM_VARS), .VAR_W(VAR_W)) u_table (
        .clk        (clk),
        .reset      (reset),
        .bt_we_i    (bt_we_i),
        .bt_var_i   (bt_var_i),
        .bt_value_i (bt_value_i),
        .req_i      (req_i),
        .req_var_i  (req_var),
        .req_mask_i (req_mask_i),
        .cand       (cand.tbl)
    );

    heuristic_selector #(.VAR_W(VAR_W)) u_sel (
        .clk           (clk),
        .reset         (reset),
        .cand          (cand.sel),
        .random_i      (random_word),
        .threshold_i   (threshold),
        .flip_valid_o  (flip_valid_o),
        .flip_var_o    (flip_var_o),
        .flip_slot_o   (flip_slot_o),
        .random_walk_o (random_walk_o)
    );

endmodule : walksat_flip_unit

// File: sim/tb_walksat_flip_unit.sv
// tb_walksat_flip_unit testbench with LCG stimulus, a cycle model of the flip unit and checks
`timescale 1ns/1ps

module tb_walksat_flip_unit;

    localparam int NUM_VARS     = 64;
    localparam int VAR_W        = 6;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 200;
    localparam int STIM_CYCLES  = 16 + 3 * N_RAND;  // idle, config, directed and drain cycles
    localparam int LIMIT        = RESET_CYCLES + STIM_CYCLES + 50;

    logic             clk;
    logic             reset;
    logic             cfg_we_i;
    logic             cfg_addr_i;
    logic [31:0]      cfg_wdata_i;
    logic             bt_we_i;
    logic [VAR_W-1:0] bt_var_i;
    logic [4:0]       bt_value_i;
    logic             req_i;
    logic [VAR_W-1:0] req_var0_i;
    logic [VAR_W-1:0] req_var1_i;
    logic [VAR_W-1:0] req_var2_i;
    logic [2:0]       req_mask_i;
    logic             flip_valid_o;
    logic [VAR_W-1:0] flip_var_o;
    logic [1:0]       flip_slot_o;
    logic             random_walk_o;

    // model state, stepped once per rising edge with the inputs the DUT sampled
    logic [4:0]            m_brk [NUM_VARS];
    logic [31:0]           m_thr;
    logic [31:0]           m_seed;
    logic                  m_seed_load;
    logic [31:0]           m_lfsr;
    logic                  m_c_valid;   // candidate stage
    logic [2:0][VAR_W-1:0] m_c_var;
    logic [2:0][4:0]       m_c_brk;
    logic [2:0]            m_c_mask;
    logic                  e_valid;     // expected outputs
    logic [VAR_W-1:0]      e_var;
    logic [1:0]            e_slot;
    logic                  e_walk;

    logic [31:0] lcg_state;
    string       test_name;
    int          cycle_cnt;
    int          requests_sent;
    int          results_seen;
    int          walks_seen;

    walksat_flip_unit #(.NUM_VARS(NUM_VARS), .VAR_W(VAR_W)) walksat_flip_unit_i (
        .clk           (clk),
        .reset         (reset),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .bt_we_i       (bt_we_i),
        .bt_var_i      (bt_var_i),
        .bt_value_i    (bt_value_i),
        .req_i         (req_i),
        .req_var0_i    (req_var0_i),
        .req_var1_i    (req_var1_i),
        .req_var2_i    (req_var2_i),
        .req_mask_i    (req_mask_i),
        .flip_valid_o  (flip_valid_o),
        .flip_var_o    (flip_var_o),
        .flip_slot_o   (flip_slot_o),
        .random_walk_o (random_walk_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 16) % n;  // upper bits, the low ones cycle quickly
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] x;
        x = s >> 1;
        if (s[0]) x = x ^ flip_cfg_pkg::LFSR_TAPS;
        return x;
    endfunction

    // returns {walk, slot} following the zero-break, random-walk and greedy rules
    function automatic logic [2:0] model_pick(input logic [2:0] mask, input logic [2:0][4:0] brk,
                                              input logic [31:0] rnd, input logic [31:0] thr);
        int cnt;
        int first;
        int last;
        int best;
        cnt   = 0;
        first = -1;
        last  = -1;
        best  = -1;
        for (int s = 0; s < 3; s++) begin
            if (mask[s]) begin
                cnt++;
                if (first < 0) first = s;
                last = s;
            end
        end
        if (cnt == 0) return {1'b0, 2'd3};
        for (int s = 0; s < 3; s++) begin
            if (mask[s] && brk[s] == 5'd0) return {1'b0, 2'(s)};
        end
        if (rnd > thr && cnt >= 2) begin
            if (cnt == 3) return {1'b1, 2'(rnd[5:0] % 3)};
            return {1'b1, rnd[7] ? 2'(last) : 2'(first)};
        end
        for (int s = 0; s < 3; s++) begin
            if (mask[s] && (best < 0 || brk[s] < brk[best])) best = s;
        end
        return {1'b0, 2'(best)};
    endfunction

    task automatic init_model();
        for (int v = 0; v < NUM_VARS; v++) m_brk[v] = 5'd0;
        m_thr       = flip_cfg_pkg::THRESHOLD_RESET;
        m_seed      = flip_cfg_pkg::SEED_RESET;
        m_lfsr      = flip_cfg_pkg::SEED_RESET;
        m_seed_load = 1'b0;
        m_c_valid   = 1'b0;
        e_valid     = 1'b0;
    endtask

    // every stage reads the old state first, so the order below matters
    task automatic step_model();
        logic [2:0] pick;
        e_valid = m_c_valid;
        if (m_c_valid) begin
            pick   = model_pick(m_c_mask, m_c_brk, m_lfsr, m_thr);
            e_walk = pick[2];
            e_slot = pick[1:0];
            e_var  = (pick[1:0] == 2'd3) ? '0 : m_c_var[pick[1:0]];
        end
        m_c_valid = req_i;
        if (req_i) begin
            m_c_var  = {req_var2_i, req_var1_i, req_var0_i};
            m_c_mask = req_mask_i;
            for (int s = 0; s < 3; s++) m_c_brk[s] = m_brk[m_c_var[s]];
        end
        if (bt_we_i) m_brk[bt_var_i] = bt_value_i;
        m_lfsr      = m_seed_load ? m_seed : lfsr_step(m_lfsr);
        m_seed_load = cfg_we_i && cfg_addr_i;
        if (cfg_we_i && !cfg_addr_i) m_thr = cfg_wdata_i;
        if (cfg_we_i && cfg_addr_i) m_seed = cfg_wdata_i;
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, field, expected, actual);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        check_value("flip_valid_o", e_valid, flip_valid_o);
        if (flip_valid_o) results_seen++;
        if (e_valid) begin
            check_value("flip_var_o", e_var, flip_var_o);
            check_value("flip_slot_o", e_slot, flip_slot_o);
            check_value("random_walk_o", e_walk, random_walk_o);
            if (e_walk) walks_seen++;
        end
    endtask

    // one clock cycle: step the model, drive the next inputs, check at the falling edge
    task automatic drive_cycle(input logic cfg_we, input logic cfg_addr, input logic [31:0] wdata,
                               input logic bt_we, input int bt_var, input int bt_val,
                               input logic req, input int v0, input int v1, input int v2,
                               input logic [2:0] mask);
        @(posedge clk);
        step_model();
        cfg_we_i    <= cfg_we;
        cfg_addr_i  <= cfg_addr;
        cfg_wdata_i <= wdata;
        bt_we_i     <= bt_we;
        bt_var_i    <= VAR_W'(bt_var);
        bt_value_i  <= 5'(bt_val);
        req_i       <= req;
        req_var0_i  <= VAR_W'(v0);
        req_var1_i  <= VAR_W'(v1);
        req_var2_i  <= VAR_W'(v2);
        req_mask_i  <= mask;
        if (req) requests_sent++;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic run_random(input int n, input bit nonzero_values, input bit seed_writes);
        logic bt_we;
        logic req;
        logic cfg_we;
        int   val;
        for (int i = 0; i < n; i++) begin
            bt_we  = rand_below(2) != 0;
            req    = rand_below(4) != 0;        // three of four cycles carry a request
            cfg_we = seed_writes && rand_below(32) == 0;
            if (nonzero_values) val = 1 + rand_below(7);
            else val = (rand_below(3) == 0) ? 0 : rand_below(8);
            drive_cycle(cfg_we, 1'b1, lcg_next() | 32'd1,
                        bt_we, rand_below(NUM_VARS), val,
                        req, rand_below(NUM_VARS), rand_below(NUM_VARS), rand_below(NUM_VARS),
                        3'(rand_below(8)));
        end
    endtask

    initial begin
        reset         = 1'b1;
        cfg_we_i      = 1'b0;
        cfg_addr_i    = 1'b0;
        cfg_wdata_i   = '0;
        bt_we_i       = 1'b0;
        bt_var_i      = '0;
        bt_value_i    = '0;
        req_i         = 1'b0;
        req_var0_i    = '0;
        req_var1_i    = '0;
        req_var2_i    = '0;
        req_mask_i    = '0;
        lcg_state     = 32'd77173;
        cycle_cnt     = 0;
        requests_sent = 0;
        results_seen  = 0;
        walks_seen    = 0;
        test_name     = "reset_idle";
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // the DUT still resets at this edge
        init_model();

        repeat (5) drive_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000);

        test_name = "zero_break";       // reset threshold, many zero counts
        run_random(N_RAND, 1'b0, 1'b0);

        test_name = "greedy";
        drive_cycle(1, flip_cfg_pkg::CFG_ADDR_THRESHOLD, 32'hFFFF_FFFF,
                    0, 0, 0, 0, 0, 0, 0, 3'b000);
        run_random(N_RAND, 1'b1, 1'b0);

        test_name = "random_walk";
        drive_cycle(1, flip_cfg_pkg::CFG_ADDR_THRESHOLD, 32'h0, 0, 0, 0, 0, 0, 0, 0, 3'b000);
        drive_cycle(1, flip_cfg_pkg::CFG_ADDR_SEED, 32'h1357_9BDF, 0, 0, 0, 0, 0, 0, 0, 3'b000);
        run_random(N_RAND, 1'b1, 1'b1);

        // var 10 starts above var 20, then drops to zero in the cycle of the first request
        test_name = "write_then_read";
        drive_cycle(1, flip_cfg_pkg::CFG_ADDR_THRESHOLD, 32'hFFFF_FFFF,
                    1, 10, 5, 0, 0, 0, 0, 3'b000);
        drive_cycle(0, 0, 0, 1, 20, 3, 0, 0, 0, 0, 3'b000);
        drive_cycle(0, 0, 0, 1, 10, 0, 1, 10, 20, 0, 3'b011);
        drive_cycle(0, 0, 0, 0, 0, 0, 1, 10, 20, 0, 3'b011);
        repeat (4) drive_cycle(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000);

        if (results_seen == requests_sent && walks_seen > 0) begin
            $display(">>> PASS");
        end else begin
            $display("%0d requests gave %0d results with %0d random walks",
                     requests_sent, results_seen, walks_seen);
            $display(">>> FAIL");
            $fatal(1);
        end
        $finish;
    end

endmodule : tb_walksat_flip_unit

// File: all.f
common/sat_pkg.sv
common/flip_cfg_pkg.sv
common/cand_if.sv
design/flip_config_regs.sv
design/walk_lfsr.sv
break_table/break_table.sv
selector/heuristic_selector.sv
design/walksat_flip_unit.sv
sim/tb_walksat_flip_unit.sv
